/* hw/mipsPkg.sv */
package mipsPkg;

    // Decoded instruction kinds, NOP is also the illegal value
    typedef enum logic [5:0] {
        NOP,
        // R-format arithmetic, logic and shifts
        ADD, SUB, ADDU, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV,
        // Register jumps
        JR, JALR,
        // Conditional moves
        MOVZ, MOVN,
        // I-format arithmetic and logic
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        // Loads and stores
        LW, LH, LHU, LB, LBU,
        SW, SH, SB,
        // Branches, REGIMM group included
        BEQ, BNE, BLEZ, BGTZ,
        BGEZ, BLTZ, BGEZAL, BLTZAL,
        // Absolute jumps
        J, JAL
    } instrKindT;

    // R-format view
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    // I-format view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFieldsT;

    // J-format view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jFieldsT;

    // One machine word seen through all three formats
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
        jFieldsT j;
    } instrWordU;

endpackage

/* hw/regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    // $zero is not stored
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write is bypassed to the readers
    assign rdataA = (raddrA == 5'd0)  ? 32'd0 :
                    (raddrA == waddr) ? wdata : regs[raddrA];
    assign rdataB = (raddrB == 5'd0)  ? 32'd0 :
                    (raddrB == waddr) ? wdata : regs[raddrB];

    // A write to a nonzero register lands in storage
    assert property (@(posedge clk) disable iff (!rstN)
        (waddr != 5'd0) |=> (regs[$past(waddr)] == $past(wdata)))
        else $error("regFile: write data not stored");

endmodule

/* hw/instrDecoder.sv */
module instrDecoder import mipsPkg::*; (
    input  instrWordU   code,
    output instrKindT   kind,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [4:0]  rd,
    output logic [4:0]  shamt,
    output logic [15:0] imm,
    output logic [25:0] target,
    output logic        ri
);

    // Cleared when no table matched the word
    logic known;

    assign rs     = code.r.rs;
    assign rt     = code.r.rt;
    assign rd     = code.r.rd;
    assign shamt  = code.r.shamt;
    assign imm    = code.i.imm;
    assign target = code.j.target;

    always_comb begin
        kind  = NOP;
        known = 1'b1;
        // All-zero word is the canonical nop, not an SLL
        if (code != '0) begin
            case (code.i.opcode)
                // SPECIAL, decoded by funct
                6'b000000: begin
                    case (code.r.funct)
                        6'b100000: kind = ADD;
                        6'b100010: kind = SUB;
                        6'b100001: kind = ADDU;
                        6'b100011: kind = SUBU;
                        6'b100100: kind = AND;
                        6'b100101: kind = OR;
                        6'b100110: kind = XOR;
                        6'b100111: kind = NOR;
                        6'b101010: kind = SLT;
                        6'b101011: kind = SLTU;
                        6'b000000: kind = SLL;
                        6'b000100: kind = SLLV;
                        6'b000010: kind = SRL;
                        6'b000110: kind = SRLV;
                        6'b000011: kind = SRA;
                        6'b000111: kind = SRAV;
                        6'b001000: kind = JR;
                        6'b001001: kind = JALR;
                        6'b001010: kind = MOVZ;
                        6'b001011: kind = MOVN;
                        default:   known = 1'b0;
                    endcase
                end
                // REGIMM, decoded by rt
                6'b000001: begin
                    case (code.i.rt)
                        5'b00000: kind = BLTZ;
                        5'b00001: kind = BGEZ;
                        5'b10000: kind = BLTZAL;
                        5'b10001: kind = BGEZAL;
                        default:  known = 1'b0;
                    endcase
                end
                6'b001000: kind = ADDI;
                6'b001001: kind = ADDIU;
                6'b001100: kind = ANDI;
                6'b001101: kind = ORI;
                6'b001110: kind = XORI;
                6'b001111: kind = LUI;
                6'b001010: kind = SLTI;
                6'b001011: kind = SLTIU;
                6'b100011: kind = LW;
                6'b100001: kind = LH;
                6'b100101: kind = LHU;
                6'b100000: kind = LB;
                6'b100100: kind = LBU;
                6'b101011: kind = SW;
                6'b101001: kind = SH;
                6'b101000: kind = SB;
                6'b000100: kind = BEQ;
                6'b000101: kind = BNE;
                6'b000110: kind = BLEZ;
                6'b000111: kind = BGTZ;
                6'b000010: kind = J;
                6'b000011: kind = JAL;
                default:   known = 1'b0;
            endcase
        end
    end

    assign ri = !known;

    // Reserved exactly when a nonzero word found no kind
    always_comb begin
        assert (ri == (code != '0 && kind == NOP))
            else $error("instrDecoder: ri %b with kind %s", ri, kind.name());
    end

endmodule

/* hw/branchCompare.sv */
module branchCompare import mipsPkg::*; (
    input  instrKindT   kind,
    input  logic [31:0] rsVal,
    input  logic [31:0] rtVal,
    output logic        cond
);

    logic rsNeg;
    logic rsZero;

    assign rsNeg  = rsVal[31];
    assign rsZero = (rsVal == 32'd0);

    always_comb begin
        case (kind)
            BEQ:          cond = (rsVal == rtVal);
            BNE:          cond = (rsVal != rtVal);
            BLEZ:         cond = rsNeg || rsZero;
            BGTZ:         cond = !rsNeg && !rsZero;
            BGEZ, BGEZAL: cond = !rsNeg;
            BLTZ, BLTZAL: cond = rsNeg;
            // Moves test rt, not rs
            MOVZ:         cond = (rtVal == 32'd0);
            MOVN:         cond = (rtVal != 32'd0);
            default:      cond = 1'b0;
        endcase
    end

endmodule

/* hw/nextPcUnit.sv */
module nextPcUnit import mipsPkg::*; (
    input  logic [31:0] pcIf,
    input  logic [31:0] pcId,
    input  instrKindT   kind,
    input  logic        cond,
    input  logic [15:0] imm,
    input  logic [25:0] target,
    input  logic [31:0] rsVal,
    output logic [31:0] nextPc
);

    logic [31:0] seqIf;
    logic [31:0] seqId;
    logic [31:0] branchOffset;

    assign seqIf = pcIf + 32'd4;
    // Delay-slot address, base for branches and jumps
    assign seqId = pcId + 32'd4;
    assign branchOffset = {{14{imm[15]}}, imm, 2'b00};

    always_comb begin
        case (kind)
            BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL:
                nextPc = cond ? (seqId + branchOffset) : seqIf;
            J, JAL:
                nextPc = {seqId[31:28], target, 2'b00};
            JR, JALR:
                nextPc = rsVal;
            default:
                nextPc = seqIf;
        endcase
    end

endmodule

/* hw/decodeStage.sv */
module decodeStage import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        flush,
    input  logic [31:0] codeId,
    input  logic [31:0] pcId,
    input  logic [4:0]  fwdAddrEx,
    input  logic [31:0] fwdDataEx,
    input  logic [4:0]  fwdAddrMem,
    input  logic [31:0] fwdDataMem,
    output logic [4:0]  raddrA,
    output logic [4:0]  raddrB,
    input  logic [31:0] rdataA,
    input  logic [31:0] rdataB,
    output instrKindT   kind,
    output logic [15:0] imm,
    output logic [25:0] target,
    output logic [31:0] rsFwd,
    output logic        cond,
    output instrKindT   instrEx,
    output logic [31:0] pcEx,
    output logic [31:0] rsDataEx,
    output logic [31:0] rtDataEx,
    output logic [15:0] immEx,
    output logic [4:0]  shamtEx,
    output logic [4:0]  rsAddrEx,
    output logic [4:0]  rtAddrEx,
    output logic [4:0]  rdAddrEx,
    output logic [4:0]  dstAddrEx,
    output logic [31:0] dstDataEx,
    output logic        riEx
);

    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [4:0]  rdAddr;
    logic [4:0]  shamt;
    logic        ri;
    logic [31:0] rtFwd;
    logic [31:0] pcPlus8;
    logic [4:0]  dstAddr;
    logic [31:0] dstData;

    instrDecoder uDecoder (
        .code(codeId), .kind(kind), .rs(rsAddr), .rt(rtAddr), .rd(rdAddr),
        .shamt(shamt), .imm(imm), .target(target), .ri(ri)
    );

    assign raddrA = rsAddr;
    assign raddrB = rtAddr;

    // EX beats MEM beats the register file; $zero never matches
    assign rsFwd = (fwdAddrEx != 5'd0 && fwdAddrEx == rsAddr)   ? fwdDataEx  :
                   (fwdAddrMem != 5'd0 && fwdAddrMem == rsAddr) ? fwdDataMem : rdataA;
    assign rtFwd = (fwdAddrEx != 5'd0 && fwdAddrEx == rtAddr)   ? fwdDataEx  :
                   (fwdAddrMem != 5'd0 && fwdAddrMem == rtAddr) ? fwdDataMem : rdataB;

    branchCompare uCompare (.kind(kind), .rsVal(rsFwd), .rtVal(rtFwd), .cond(cond));

    assign pcPlus8 = pcId + 32'd8;

    // Write-back target, plus data already known in ID
    always_comb begin
        dstAddr = 5'd0;
        dstData = 32'd0;
        case (kind)
            BGEZAL, BLTZAL: begin
                // Link only when the branch is taken
                dstAddr = cond ? 5'd31 : 5'd0;
                dstData = pcPlus8;
            end
            MOVZ, MOVN: begin
                dstAddr = cond ? rdAddr : 5'd0;
                dstData = cond ? rsFwd : 32'd0;
            end
            JAL: begin
                dstAddr = 5'd31;
                dstData = pcPlus8;
            end
            JALR: begin
                dstAddr = rdAddr;
                dstData = pcPlus8;
            end
            ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
            SLL, SLLV, SRL, SRLV, SRA, SRAV:
                dstAddr = rdAddr;
            ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LW, LH, LHU, LB, LBU:
                dstAddr = rtAddr;
            LUI: begin
                dstAddr = rtAddr;
                dstData = {imm, 16'h0000};
            end
            default: dstAddr = 5'd0;
        endcase
    end

    // ID/EX register, flush wins over stall
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            instrEx   <= NOP;
            pcEx      <= 32'd0;
            rsDataEx  <= 32'd0;
            rtDataEx  <= 32'd0;
            immEx     <= 16'd0;
            shamtEx   <= 5'd0;
            rsAddrEx  <= 5'd0;
            rtAddrEx  <= 5'd0;
            rdAddrEx  <= 5'd0;
            dstAddrEx <= 5'd0;
            dstDataEx <= 32'd0;
            riEx      <= 1'b0;
        end else if (!stall) begin
            instrEx   <= kind;
            pcEx      <= pcId;
            rsDataEx  <= rsFwd;
            rtDataEx  <= rtFwd;
            immEx     <= imm;
            shamtEx   <= shamt;
            rsAddrEx  <= rsAddr;
            rtAddrEx  <= rtAddr;
            rdAddrEx  <= rdAddr;
            dstAddrEx <= dstAddr;
            dstDataEx <= dstData;
            riEx      <= ri;
        end
    end

    // Flushed slot must reach EX as a clean bubble
    assert property (@(posedge clk) flush |=> (instrEx == NOP && !riEx && dstAddrEx == 5'd0))
        else $error("decodeStage: ID/EX not a bubble after flush");

endmodule

/* hw/decodeTop.sv */
module decodeTop import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        flush,
    input  logic [31:0] pcIf,
    input  logic [31:0] codeId,
    input  logic [31:0] pcId,
    input  logic [4:0]  fwdAddrEx,
    input  logic [31:0] fwdDataEx,
    input  logic [4:0]  fwdAddrMem,
    input  logic [31:0] fwdDataMem,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData,
    output logic [31:0] nextPc,
    output logic        takenId,
    output instrKindT   instrEx,
    output logic [31:0] pcEx,
    output logic [31:0] rsDataEx,
    output logic [31:0] rtDataEx,
    output logic [15:0] immEx,
    output logic [4:0]  shamtEx,
    output logic [4:0]  rsAddrEx,
    output logic [4:0]  rtAddrEx,
    output logic [4:0]  rdAddrEx,
    output logic [4:0]  dstAddrEx,
    output logic [31:0] dstDataEx,
    output logic        riEx
);

    logic [4:0]  raddrA;
    logic [4:0]  raddrB;
    logic [31:0] rdataA;
    logic [31:0] rdataB;
    instrKindT   kind;
    logic [15:0] imm;
    logic [25:0] target;
    logic [31:0] rsFwd;

    regFile uRegFile (
        .clk(clk), .rstN(rstN), .raddrA(raddrA), .raddrB(raddrB),
        .rdataA(rdataA), .rdataB(rdataB), .waddr(wbAddr), .wdata(wbData)
    );

    // Branch condition doubles as the taken flag
    decodeStage uDecodeStage (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .codeId(codeId), .pcId(pcId),
        .fwdAddrEx(fwdAddrEx), .fwdDataEx(fwdDataEx),
        .fwdAddrMem(fwdAddrMem), .fwdDataMem(fwdDataMem),
        .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
        .kind(kind), .imm(imm), .target(target), .rsFwd(rsFwd), .cond(takenId),
        .instrEx(instrEx), .pcEx(pcEx), .rsDataEx(rsDataEx), .rtDataEx(rtDataEx),
        .immEx(immEx), .shamtEx(shamtEx), .rsAddrEx(rsAddrEx), .rtAddrEx(rtAddrEx),
        .rdAddrEx(rdAddrEx), .dstAddrEx(dstAddrEx), .dstDataEx(dstDataEx), .riEx(riEx)
    );

    nextPcUnit uNextPc (
        .pcIf(pcIf), .pcId(pcId), .kind(kind), .cond(takenId), .imm(imm),
        .target(target), .rsVal(rsFwd), .nextPc(nextPc)
    );

endmodule

/* tb/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Instruction kind from the MIPS encoding tables
function automatic void decodeWord(input logic [31:0] w, output instrKindT k,
                                   output logic ri);
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] sel;
    op = w[31:26];
    fn = w[5:0];
    sel = w[20:16];
    k = NOP;
    ri = 1'b0;
    if (w == 32'd0) begin
        return;
    end
    case (op)
        6'h00: begin
            case (fn)
                6'h20: k = ADD;
                6'h22: k = SUB;
                6'h21: k = ADDU;
                6'h23: k = SUBU;
                6'h24: k = AND;
                6'h25: k = OR;
                6'h26: k = XOR;
                6'h27: k = NOR;
                6'h2a: k = SLT;
                6'h2b: k = SLTU;
                6'h00: k = SLL;
                6'h04: k = SLLV;
                6'h02: k = SRL;
                6'h06: k = SRLV;
                6'h03: k = SRA;
                6'h07: k = SRAV;
                6'h08: k = JR;
                6'h09: k = JALR;
                6'h0a: k = MOVZ;
                6'h0b: k = MOVN;
                default: k = NOP;
            endcase
        end
        6'h01: begin
            case (sel)
                5'h00: k = BLTZ;
                5'h01: k = BGEZ;
                5'h10: k = BLTZAL;
                5'h11: k = BGEZAL;
                default: k = NOP;
            endcase
        end
        6'h08: k = ADDI;
        6'h09: k = ADDIU;
        6'h0c: k = ANDI;
        6'h0d: k = ORI;
        6'h0e: k = XORI;
        6'h0f: k = LUI;
        6'h0a: k = SLTI;
        6'h0b: k = SLTIU;
        6'h23: k = LW;
        6'h21: k = LH;
        6'h25: k = LHU;
        6'h20: k = LB;
        6'h24: k = LBU;
        6'h2b: k = SW;
        6'h29: k = SH;
        6'h28: k = SB;
        6'h04: k = BEQ;
        6'h05: k = BNE;
        6'h06: k = BLEZ;
        6'h07: k = BGTZ;
        6'h02: k = J;
        6'h03: k = JAL;
        default: k = NOP;
    endcase
    // Nonzero word without a match is a reserved instruction
    ri = (k == NOP);
endfunction

// Operand seen by ID: EX, then MEM, then the register file with write bypass
function automatic logic [31:0] forwardedOperand(input logic [4:0] addr,
                                                 input logic [4:0] exA, input logic [31:0] exD,
                                                 input logic [4:0] memA, input logic [31:0] memD,
                                                 input logic [4:0] wbA, input logic [31:0] wbD,
                                                 input logic [31:0] stored);
    if (addr == 5'd0) begin
        return 32'd0;
    end
    if (exA == addr) begin
        return exD;
    end
    if (memA == addr) begin
        return memD;
    end
    if (wbA == addr) begin
        return wbD;
    end
    return stored;
endfunction

function automatic logic conditionMet(input instrKindT k, input logic [31:0] a,
                                      input logic [31:0] b);
    case (k)
        BEQ:          return a == b;
        BNE:          return a != b;
        BLEZ:         return $signed(a) <= 0;
        BGTZ:         return $signed(a) > 0;
        BGEZ, BGEZAL: return $signed(a) >= 0;
        BLTZ, BLTZAL: return $signed(a) < 0;
        MOVZ:         return b == 32'd0;
        MOVN:         return b != 32'd0;
        default:      return 1'b0;
    endcase
endfunction

function automatic void writeBackTarget(input instrKindT k, input logic c,
                                        input logic [31:0] w, input logic [31:0] pc,
                                        input logic [31:0] rsVal,
                                        output logic [4:0] addr, output logic [31:0] data);
    addr = 5'd0;
    data = 32'd0;
    if (k inside {BGEZAL, BLTZAL}) begin
        addr = c ? 5'd31 : 5'd0;
        data = pc + 32'd8;
    end else if (k inside {MOVZ, MOVN}) begin
        if (c) begin
            addr = w[15:11];
            data = rsVal;
        end
    end else if (k == JAL) begin
        addr = 5'd31;
        data = pc + 32'd8;
    end else if (k == JALR) begin
        addr = w[15:11];
        data = pc + 32'd8;
    end else if (k == LUI) begin
        addr = w[20:16];
        data = {w[15:0], 16'h0000};
    end else if (k inside {ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
                           SLL, SLLV, SRL, SRLV, SRA, SRAV}) begin
        addr = w[15:11];
    end else if (k inside {ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU,
                           LW, LH, LHU, LB, LBU}) begin
        addr = w[20:16];
    end
endfunction

function automatic logic [31:0] nextFetchAddr(input instrKindT k, input logic c,
                                              input logic [31:0] w, input logic [31:0] pcF,
                                              input logic [31:0] pcD, input logic [31:0] rsVal);
    logic [31:0] slot;
    slot = pcD + 32'd4;
    if (c && (k inside {BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL})) begin
        return slot + ({{16{w[15]}}, w[15:0]} << 2);
    end
    if (k == J || k == JAL) begin
        return {slot[31:28], w[25:0], 2'b00};
    end
    if (k == JR || k == JALR) begin
        return rsVal;
    end
    return pcF + 32'd4;
endfunction

`endif

/* tb/decodeTb.sv */
module decodeTb import mipsPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    `include "decodeModel.svh"

    localparam int numVectors = 2000;
    localparam int clkPeriod = 10;
    // Reset, all vectors, and some slack
    localparam int watchdogNs = (numVectors + 4) * clkPeriod + 500;

    localparam logic [5:0] specialFuncts [20] = '{
        6'h20, 6'h22, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b,
        6'h00, 6'h04, 6'h02, 6'h06, 6'h03, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b
    };
    localparam logic [4:0] regimmRts [4] = '{5'h00, 5'h01, 5'h10, 5'h11};
    localparam logic [5:0] plainOps [22] = '{
        6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h0a, 6'h0b, 6'h23, 6'h21, 6'h25,
        6'h20, 6'h24, 6'h2b, 6'h29, 6'h28, 6'h04, 6'h05, 6'h06, 6'h07, 6'h02, 6'h03
    };

    // Expected ID/EX contents, all zero is the bubble
    typedef struct packed {
        instrKindT   instr;
        logic [31:0] pc;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [15:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  rsAddr;
        logic [4:0]  rtAddr;
        logic [4:0]  rdAddr;
        logic [4:0]  dstAddr;
        logic [31:0] dstData;
        logic        ri;
    } idExT;

    logic        clk = 1'b0;
    logic        rstN;
    logic        stall;
    logic        flush;
    logic [31:0] pcIf;
    logic [31:0] codeId;
    logic [31:0] pcId;
    logic [4:0]  fwdAddrEx;
    logic [31:0] fwdDataEx;
    logic [4:0]  fwdAddrMem;
    logic [31:0] fwdDataMem;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic [31:0] nextPc;
    logic        takenId;
    instrKindT   instrEx;
    logic [31:0] pcEx;
    logic [31:0] rsDataEx;
    logic [31:0] rtDataEx;
    logic [15:0] immEx;
    logic [4:0]  shamtEx;
    logic [4:0]  rsAddrEx;
    logic [4:0]  rtAddrEx;
    logic [4:0]  rdAddrEx;
    logic [4:0]  dstAddrEx;
    logic [31:0] dstDataEx;
    logic        riEx;

    logic [31:0] shadowRegs [32];
    idExT        expState;
    int          errorCount = 0;
    int          checkCount = 0;

    decodeTop dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // Mirror of the register file contents
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                shadowRegs[i] <= 32'd0;
            end
        end else if (wbAddr != 5'd0) begin
            shadowRegs[wbAddr] <= wbData;
        end
    end

    function automatic int randBelow(int n);
        return int'($urandom % 32'(n));
    endfunction

    // Mostly rs or rt, so forwarding paths get hit often
    function automatic logic [4:0] pickAddr(logic [4:0] rs, logic [4:0] rt);
        int r;
        r = randBelow(10);
        if (r < 4) begin
            return rs;
        end
        if (r < 6) begin
            return rt;
        end
        return 5'($urandom);
    endfunction

    function automatic logic [31:0] makeWord();
        logic [31:0] w;
        int pick;
        int illegalSel;
        pick = randBelow(100);
        w = $urandom;
        if (pick < 5) begin
            return 32'd0;
        end
        if (pick < 15) begin
            illegalSel = randBelow(3);
            if (illegalSel == 0) begin
                // Opcodes 0x10 to 0x1f are not decoded
                w[31:26] = {2'b01, w[29:26]};
            end else if (illegalSel == 1) begin
                // SPECIAL functs 0x10 to 0x1f
                w[31:26] = 6'h00;
                w[5:0] = {2'b01, w[3:0]};
            end else begin
                // REGIMM rt 0x08 to 0x0f
                w[31:26] = 6'h01;
                w[20:16] = {2'b01, w[18:16]};
            end
            return w;
        end
        if (pick < 55) begin
            w[31:26] = 6'h00;
            w[5:0] = specialFuncts[randBelow(20)];
        end else if (pick < 67) begin
            w[31:26] = 6'h01;
            w[20:16] = regimmRts[randBelow(4)];
        end else begin
            w[31:26] = plainOps[randBelow(22)];
        end
        // Some $zero operands for the zero tests
        if (randBelow(6) == 0) begin
            w[25:21] = 5'd0;
        end
        if (randBelow(6) == 0 && w[31:26] != 6'h01) begin
            w[20:16] = 5'd0;
        end
        return w;
    endfunction

    task automatic checkKind(string name, instrKindT expVal, instrKindT actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("ERROR %0t %s: expected %s, actual %s",
                     $time, name, expVal.name(), actVal.name());
        end
    endtask

    task automatic checkWord(string name, logic [31:0] expVal, logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("ERROR %0t %s: expected %h, actual %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic checkFlag(string name, logic expVal, logic actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("ERROR %0t %s: expected %b, actual %b", $time, name, expVal, actVal);
        end
    endtask

    task automatic compareIdEx();
        checkKind("instrEx", expState.instr, instrEx);
        checkWord("pcEx", expState.pc, pcEx);
        checkWord("rsDataEx", expState.rsData, rsDataEx);
        checkWord("rtDataEx", expState.rtData, rtDataEx);
        checkWord("immEx", 32'(expState.imm), 32'(immEx));
        checkWord("shamtEx", 32'(expState.shamt), 32'(shamtEx));
        checkWord("rsAddrEx", 32'(expState.rsAddr), 32'(rsAddrEx));
        checkWord("rtAddrEx", 32'(expState.rtAddr), 32'(rtAddrEx));
        checkWord("rdAddrEx", 32'(expState.rdAddr), 32'(rdAddrEx));
        checkWord("dstAddrEx", 32'(expState.dstAddr), 32'(dstAddrEx));
        checkWord("dstDataEx", expState.dstData, dstDataEx);
        checkFlag("riEx", expState.ri, riEx);
    endtask

    task automatic driveInputs();
        logic [4:0] rs;
        logic [4:0] rt;
        codeId = makeWord();
        rs = codeId[25:21];
        rt = codeId[20:16];
        pcIf = $urandom & 32'hffff_fffc;
        pcId = $urandom & 32'hffff_fffc;
        stall = (randBelow(100) < 15);
        flush = (randBelow(100) < 8);
        fwdAddrEx = pickAddr(rs, rt);
        fwdAddrMem = pickAddr(rs, rt);
        wbAddr = pickAddr(rs, rt);
        fwdDataEx = $urandom;
        fwdDataMem = $urandom;
        wbData = $urandom;
        if (randBelow(8) == 0) begin
            fwdDataEx = 32'd0;
        end
        // Equal operands so BEQ and BNE go both ways
        if (randBelow(5) == 0) begin
            fwdAddrEx = rs;
            fwdAddrMem = rt;
            fwdDataMem = fwdDataEx;
        end
    endtask

    // Checks the same-cycle outputs, then advances the expected ID/EX state
    task automatic predictCycle();
        instrKindT   k;
        logic        ri;
        logic        c;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [4:0]  dAddr;
        logic [31:0] dData;
        idExT        nxt;
        decodeWord(codeId, k, ri);
        rsVal = forwardedOperand(codeId[25:21], fwdAddrEx, fwdDataEx, fwdAddrMem, fwdDataMem,
                                 wbAddr, wbData, shadowRegs[codeId[25:21]]);
        rtVal = forwardedOperand(codeId[20:16], fwdAddrEx, fwdDataEx, fwdAddrMem, fwdDataMem,
                                 wbAddr, wbData, shadowRegs[codeId[20:16]]);
        c = conditionMet(k, rsVal, rtVal);
        writeBackTarget(k, c, codeId, pcId, rsVal, dAddr, dData);
        checkFlag("takenId", c, takenId);
        checkWord("nextPc", nextFetchAddr(k, c, codeId, pcIf, pcId, rsVal), nextPc);
        nxt.instr = k;
        nxt.pc = pcId;
        nxt.rsData = rsVal;
        nxt.rtData = rtVal;
        nxt.imm = codeId[15:0];
        nxt.shamt = codeId[10:6];
        nxt.rsAddr = codeId[25:21];
        nxt.rtAddr = codeId[20:16];
        nxt.rdAddr = codeId[15:11];
        nxt.dstAddr = dAddr;
        nxt.dstData = dData;
        nxt.ri = ri;
        if (flush) begin
            expState = '0;
        end else if (!stall) begin
            expState = nxt;
        end
    endtask

    initial begin
        void'($urandom(32'hf54b_5462));
        rstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        pcIf = 32'd0;
        codeId = 32'd0;
        pcId = 32'd0;
        fwdAddrEx = 5'd0;
        fwdDataEx = 32'd0;
        fwdAddrMem = 5'd0;
        fwdDataMem = 32'd0;
        wbAddr = 5'd0;
        wbData = 32'd0;
        expState = '0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        for (int n = 0; n < numVectors; n++) begin
            compareIdEx();
            driveInputs();
            #1;
            predictCycle();
            @(negedge clk);
        end
        compareIdEx();
        $display("Errors: %0d in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: the run did not finish in %0d ns", watchdogNs);
        $display("Test failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+tb
hw/mipsPkg.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/branchCompare.sv
hw/nextPcUnit.sv
hw/decodeStage.sv
hw/decodeTop.sv
tb/decodeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decodeTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation finished without failure"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
